// File: rtl/mipsSettings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Instruction queue slots, also the sender's starting credit count
`define MIPS_QUEUE_DEPTH 4

// Data memory depth in 32-bit words
`define MIPS_DMEM_WORDS 64

// Opcodes, bits 31:26
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_ADDI  6'h08
`define MIPS_OP_LW    6'h23
`define MIPS_OP_SW    6'h2B

// R-type funct codes, bits 5:0
`define MIPS_FN_ADD 6'h20
`define MIPS_FN_SUB 6'h22
`define MIPS_FN_AND 6'h24
`define MIPS_FN_OR  6'h25
`define MIPS_FN_SLT 6'h2A
`define MIPS_FN_SLL 6'h00  // Shared with the all-zero nop word

`endif

// File: rtl/mipsPkg.sv
package mipsPkg;

  typedef logic [31:0] word_t;     // Data word or raw instruction
  typedef logic [4:0]  regAddr_t;  // Register number
  typedef logic [2:0]  aluOp_t;    // ALU operation select

  // ALU operations
  localparam aluOp_t aluAdd = 3'd0;
  localparam aluOp_t aluSub = 3'd1;
  localparam aluOp_t aluAnd = 3'd2;
  localparam aluOp_t aluOr  = 3'd3;
  localparam aluOp_t aluSlt = 3'd4;  // Signed compare
  localparam aluOp_t aluSll = 3'd5;  // Shift by shamt

  // Decode to execute register
  typedef struct packed {
    logic       valid;
    aluOp_t     aluOp;
    logic       aluSrcImm;  // Operand B is the immediate
    logic       memRead;
    logic       memWrite;
    logic       regWrite;
    regAddr_t   rs;
    regAddr_t   rt;
    regAddr_t   dest;       // Already rd or rt
    logic [4:0] shamt;
    word_t      readData1;
    word_t      readData2;
    word_t      imm;        // Sign-extended
  } decodeBundle_t;

  // Execute to result register
  typedef struct packed {
    logic     valid;
    logic     memRead;
    logic     memWrite;
    logic     regWrite;
    regAddr_t dest;
    word_t    aluResult;  // Also the load/store address
    word_t    storeData;  // Forwarded rt value
  } execBundle_t;

  // One register write
  typedef struct packed {
    regAddr_t dest;
    word_t    data;
  } wbResult_t;

endpackage

// File: rtl/registerFile.sv
module registerFile (
  input  logic               Clk,
  input  logic               rstN,
  input  mipsPkg::regAddr_t  rs,
  input  mipsPkg::regAddr_t  rt,
  output mipsPkg::word_t     readData1,
  output mipsPkg::word_t     readData2,
  input  logic               wbValid,
  input  mipsPkg::wbResult_t wbResult
);
  import mipsPkg::*;

  word_t regs [1:31];  // $zero has no storage

  // One read port, write data bypasses the array
  function automatic word_t readPort(input regAddr_t addr);
    if (addr == '0)
      return '0;
    else if (wbValid && wbResult.dest == addr)
      return wbResult.data;  // Same-cycle write wins
    else
      return regs[addr];
  endfunction

  always_comb begin
    readData1 = readPort(rs);
    readData2 = readPort(rt);
  end

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (wbValid && wbResult.dest != '0) begin
      regs[wbResult.dest] <= wbResult.data;
    end
  end

  // Result stage filters $zero writes before they get here
  assert property (@(posedge Clk) disable iff (!rstN) wbValid |-> wbResult.dest != '0)
    else $error("Write-back to register 0 requested");

endmodule

// File: rtl/decodeStage.sv
`include "mipsSettings.svh"

module decodeStage (
  input  logic                   Clk,
  input  logic                   rstN,
  input  logic                   instrValid,
  input  mipsPkg::word_t         instr,
  output logic                   instrCredit,
  output mipsPkg::regAddr_t      rs,
  output mipsPkg::regAddr_t      rt,
  input  mipsPkg::word_t         readData1,
  input  mipsPkg::word_t         readData2,
  output mipsPkg::decodeBundle_t decodeOut
);
  import mipsPkg::*;

  localparam int ptrW = $clog2(`MIPS_QUEUE_DEPTH);
  localparam int cntW = $clog2(`MIPS_QUEUE_DEPTH + 1);

  word_t         queueMem [`MIPS_QUEUE_DEPTH];  // Circular instruction buffer
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] queueCount;
  logic          queueEmpty;
  logic          queueFull;
  logic          loadUseStall;
  logic          popEn;
  word_t         head;
  logic [5:0]    opcode;
  logic [5:0]    funct;
  regAddr_t      rd;
  decodeBundle_t nextBundle;

  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    return (ptr == ptrW'(`MIPS_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign queueEmpty = (queueCount == '0);
  assign queueFull  = (queueCount == cntW'(`MIPS_QUEUE_DEPTH));
  assign head       = queueMem[rdPtr];

  // Field split of the head instruction
  assign opcode = head[31:26];
  assign rs     = head[25:21];  // Straight to the register file
  assign rt     = head[20:16];
  assign rd     = head[15:11];
  assign funct  = head[5:0];

  // Load one slot ahead whose dest feeds the head
  assign loadUseStall = decodeOut.valid && decodeOut.memRead && (decodeOut.dest != '0) &&
                        ((decodeOut.dest == rs) || (decodeOut.dest == rt));
  assign popEn       = !queueEmpty && !loadUseStall;
  assign instrCredit = popEn;  // Credit leaves with the instruction

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      queueCount <= '0;
    end else begin
      if (instrValid)
        wrPtr <= nextPtr(wrPtr);
      if (popEn)
        rdPtr <= nextPtr(rdPtr);
      queueCount <= queueCount + cntW'(instrValid) - cntW'(popEn);
    end
  end

  always_ff @(posedge Clk) begin
    if (instrValid)
      queueMem[wrPtr] <= instr;
  end

  // Control decode and sign extension
  always_comb begin
    nextBundle           = '0;  // Unknown encodings stay a no-op
    nextBundle.valid     = 1'b1;
    nextBundle.aluOp     = aluAdd;
    nextBundle.rs        = rs;
    nextBundle.rt        = rt;
    nextBundle.dest      = rt;  // I-type target
    nextBundle.shamt     = head[10:6];
    nextBundle.readData1 = readData1;
    nextBundle.readData2 = readData2;
    nextBundle.imm       = {{16{head[15]}}, head[15:0]};
    case (opcode)
      `MIPS_OP_RTYPE: begin
        nextBundle.dest     = rd;
        nextBundle.regWrite = 1'b1;
        case (funct)
          `MIPS_FN_ADD: nextBundle.aluOp = aluAdd;
          `MIPS_FN_SUB: nextBundle.aluOp = aluSub;
          `MIPS_FN_AND: nextBundle.aluOp = aluAnd;
          `MIPS_FN_OR:  nextBundle.aluOp = aluOr;
          `MIPS_FN_SLT: nextBundle.aluOp = aluSlt;
          `MIPS_FN_SLL: nextBundle.aluOp = aluSll;
          default:      nextBundle.regWrite = 1'b0;
        endcase
      end
      `MIPS_OP_ADDI: begin
        nextBundle.aluSrcImm = 1'b1;
        nextBundle.regWrite  = 1'b1;
      end
      `MIPS_OP_LW: begin
        nextBundle.aluSrcImm = 1'b1;  // Address is rs plus offset
        nextBundle.memRead   = 1'b1;
        nextBundle.regWrite  = 1'b1;
      end
      `MIPS_OP_SW: begin
        nextBundle.aluSrcImm = 1'b1;
        nextBundle.memWrite  = 1'b1;
      end
      default: nextBundle.regWrite = 1'b0;
    endcase
  end

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN)
      decodeOut <= '0;
    else if (popEn)
      decodeOut <= nextBundle;
    else
      decodeOut <= '0;  // Bubble on stall or empty queue
  end

  // Sender spends a credit per push, so a full queue only takes a push it pops too
  assert property (@(posedge Clk) disable iff (!rstN) instrValid && queueFull |-> popEn)
    else $error("Instruction queue overflow");

  // Count and pointers are tracked apart and must agree
  assert property (@(posedge Clk) disable iff (!rstN)
    (wrPtr == rdPtr) == (queueEmpty || queueFull))
    else $error("Queue count disagrees with the pointers");

endmodule

// File: rtl/executeStage.sv
module executeStage (
  input  logic                   Clk,
  input  logic                   rstN,
  input  mipsPkg::decodeBundle_t decodeIn,
  input  logic                   wbValid,
  input  mipsPkg::wbResult_t     wbResult,
  output mipsPkg::execBundle_t   execOut
);
  import mipsPkg::*;

  word_t srcA;       // Forwarded rs
  word_t srcB;       // Forwarded rt, also the store data
  word_t opB;
  word_t aluResult;

  // Youngest producer first, then write-back, then the register read
  function automatic word_t forward(input regAddr_t src, input word_t regValue,
                                    input execBundle_t ex, input logic wbV,
                                    input wbResult_t wb);
    if (ex.valid && ex.regWrite && ex.dest != '0 && ex.dest == src)
      return ex.aluResult;
    else if (wbV && wb.dest != '0 && wb.dest == src)
      return wb.data;
    else
      return regValue;
  endfunction

  assign srcA = forward(decodeIn.rs, decodeIn.readData1, execOut, wbValid, wbResult);
  assign srcB = forward(decodeIn.rt, decodeIn.readData2, execOut, wbValid, wbResult);
  assign opB  = decodeIn.aluSrcImm ? decodeIn.imm : srcB;

  always_comb begin
    case (decodeIn.aluOp)
      aluAdd:  aluResult = srcA + opB;
      aluSub:  aluResult = srcA - opB;
      aluAnd:  aluResult = srcA & opB;
      aluOr:   aluResult = srcA | opB;
      aluSlt:  aluResult = {31'b0, $signed(srcA) < $signed(opB)};
      aluSll:  aluResult = opB << decodeIn.shamt;  // MIPS shifts rt
      default: aluResult = '0;
    endcase
  end

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      execOut <= '0;
    end else begin
      execOut.valid     <= decodeIn.valid;
      execOut.memRead   <= decodeIn.valid & decodeIn.memRead;
      execOut.memWrite  <= decodeIn.valid & decodeIn.memWrite;
      execOut.regWrite  <= decodeIn.valid & decodeIn.regWrite;
      execOut.dest      <= decodeIn.dest;
      execOut.aluResult <= aluResult;
      execOut.storeData <= srcB;
    end
  end

  // Decode stall keeps load data from being needed one stage too early
  assert property (@(posedge Clk) disable iff (!rstN)
    decodeIn.valid && execOut.valid && execOut.memRead && execOut.dest != '0 |->
      execOut.dest != decodeIn.rs && execOut.dest != decodeIn.rt)
    else $error("Load result needed before it is read from memory");

endmodule

// File: rtl/resultStage.sv
`include "mipsSettings.svh"

module resultStage (
  input  logic                 Clk,
  input  logic                 rstN,
  input  mipsPkg::execBundle_t execIn,
  output logic                 wbValid,
  output mipsPkg::wbResult_t   wbResult
);
  import mipsPkg::*;

  localparam int idxW = $clog2(`MIPS_DMEM_WORDS);

  word_t           dataMem [`MIPS_DMEM_WORDS];
  logic [idxW-1:0] wordIdx;
  word_t           loadData;

  assign wordIdx  = execIn.aluResult[idxW+1:2];  // Byte offset dropped
  assign loadData = dataMem[wordIdx];            // Async read

  // Stores land at the edge
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `MIPS_DMEM_WORDS; i++)
        dataMem[i] <= '0;
    end else if (execIn.valid && execIn.memWrite) begin
      dataMem[wordIdx] <= execIn.storeData;
    end
  end

  // Write-back select and result register
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      wbValid  <= 1'b0;
      wbResult <= '0;
    end else begin
      wbValid       <= execIn.valid && execIn.regWrite && (execIn.dest != '0);
      wbResult.dest <= execIn.dest;
      wbResult.data <= execIn.memRead ? loadData : execIn.aluResult;
    end
  end

  // Decode never sets both memory controls
  assert property (@(posedge Clk) disable iff (!rstN)
    execIn.valid |-> !(execIn.memRead && execIn.memWrite))
    else $error("Load and store flagged together");

endmodule

// File: rtl/pipelineTop.sv
module pipelineTop (
  input  logic               Clk,
  input  logic               rstN,
  input  logic               instrValid,
  input  mipsPkg::word_t     instr,
  output logic               instrCredit,
  output logic               wbValid,
  output mipsPkg::wbResult_t wbResult
);
  import mipsPkg::*;

  regAddr_t      rs;
  regAddr_t      rt;
  word_t         readData1;
  word_t         readData2;
  decodeBundle_t decodeBundle;  // Decode to execute
  execBundle_t   execBundle;    // Execute to result

  decodeStage u_decode (
    .Clk(Clk), .rstN(rstN),
    .instrValid(instrValid), .instr(instr), .instrCredit(instrCredit),
    .rs(rs), .rt(rt), .readData1(readData1), .readData2(readData2),
    .decodeOut(decodeBundle)
  );

  registerFile u_regFile (
    .Clk(Clk), .rstN(rstN),
    .rs(rs), .rt(rt), .readData1(readData1), .readData2(readData2),
    .wbValid(wbValid), .wbResult(wbResult)
  );

  executeStage u_execute (
    .Clk(Clk), .rstN(rstN),
    .decodeIn(decodeBundle),
    .wbValid(wbValid), .wbResult(wbResult),  // Second forwarding source
    .execOut(execBundle)
  );

  resultStage u_result (
    .Clk(Clk), .rstN(rstN),
    .execIn(execBundle),
    .wbValid(wbValid), .wbResult(wbResult)
  );

endmodule

// File: testbench/pipelineTb.sv
`include "mipsSettings.svh"

module pipelineTb;
  timeunit 1ns;
  timeprecision 1ps;
  import mipsPkg::*;

  localparam int waitLimit = 100;  // Cycles allowed per wait

  // One program step and the register write it should cause
  typedef struct packed {
    word_t    instr;
    logic     expWb;
    regAddr_t dest;
    word_t    data;
  } stimRow_t;

  logic      Clk;
  logic      rstN;
  logic      instrValid;
  word_t     instr;
  logic      instrCredit;
  logic      wbValid;
  wbResult_t wbResult;

  stimRow_t    stimTable[$];
  int          expRows[$];  // Table rows that write a register, in order
  int          burstStart;  // First row of the gapless load burst
  int          wbSeen;
  int          credits;     // Sender side credit counter
  int          destErrors;
  int          dataErrors;
  int          countErrors;
  logic        timedOut;
  logic        creditsRanOut;
  logic [15:0] lfsr;

  pipelineTop u_dut (
    .Clk(Clk), .rstN(rstN),
    .instrValid(instrValid), .instr(instr), .instrCredit(instrCredit),
    .wbValid(wbValid), .wbResult(wbResult)
  );

  initial begin
    Clk = 1'b0;
    forever #20 Clk = ~Clk;  // 40 ns period
  end

  function automatic word_t rType(input regAddr_t rs, input regAddr_t rt, input regAddr_t rd,
                                  input logic [4:0] shamt, input logic [5:0] funct);
    return {`MIPS_OP_RTYPE, rs, rt, rd, shamt, funct};
  endfunction

  function automatic word_t iType(input logic [5:0] op, input regAddr_t rs, input regAddr_t rt,
                                  input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  // Mostly zero so bursts happen
  function automatic int drawGap();
    logic [2:0] v;
    for (int i = 0; i < 3; i++)
      v[i] = lfsrBit();
    return (v > 3'd3) ? 0 : int'(v);
  endfunction

  task automatic addRow(input word_t word, input logic expWb, input regAddr_t dest,
                        input word_t data);
    stimTable.push_back(stimRow_t'{word, expWb, dest, data});
  endtask

  // Expected values follow sequential MIPS execution, registers start at zero
  task automatic buildTable();
    addRow(iType(`MIPS_OP_ADDI, 0, 1, 16'd5), 1, 1, 32'h0000_0005);
    addRow(iType(`MIPS_OP_ADDI, 0, 2, 16'hFFFD), 1, 2, 32'hFFFF_FFFD);  // -3
    addRow(rType(1, 2, 3, 0, `MIPS_FN_ADD), 1, 3, 32'h0000_0002);
    addRow(rType(3, 1, 4, 0, `MIPS_FN_SUB), 1, 4, 32'hFFFF_FFFD);
    addRow(rType(4, 1, 5, 0, `MIPS_FN_AND), 1, 5, 32'h0000_0005);
    addRow(rType(5, 2, 6, 0, `MIPS_FN_OR), 1, 6, 32'hFFFF_FFFD);
    addRow(rType(6, 1, 7, 0, `MIPS_FN_SLT), 1, 7, 32'h0000_0001);  // -3 < 5
    addRow(rType(0, 7, 8, 4, `MIPS_FN_SLL), 1, 8, 32'h0000_0010);
    addRow(iType(`MIPS_OP_ADDI, 8, 9, 16'hFFEC), 1, 9, 32'hFFFF_FFFC);  // 16 - 20
    addRow(iType(`MIPS_OP_SW, 0, 9, 16'd8), 0, 0, 32'h0);
    addRow(iType(`MIPS_OP_LW, 0, 10, 16'd8), 1, 10, 32'hFFFF_FFFC);
    addRow(rType(10, 1, 11, 0, `MIPS_FN_ADD), 1, 11, 32'h0000_0001);  // Load-use on rs
    addRow(rType(1, 1, 0, 0, `MIPS_FN_ADD), 0, 0, 32'h0);  // $zero target
    addRow(32'hFC00_0000, 0, 0, 32'h0);  // Unknown opcode
    addRow(rType(1, 2, 12, 0, 6'h3F), 0, 0, 32'h0);  // Unknown funct
    addRow(rType(0, 3, 12, 0, `MIPS_FN_ADD), 1, 12, 32'h0000_0002);  // $zero reads 0
    addRow(iType(`MIPS_OP_SW, 1, 6, 16'd15), 0, 0, 32'h0);  // Address 20
    addRow(iType(`MIPS_OP_LW, 1, 13, 16'd15), 1, 13, 32'hFFFF_FFFD);
    addRow(rType(1, 13, 14, 0, `MIPS_FN_SLT), 1, 14, 32'h0000_0000);  // Load-use on rt
    addRow(rType(13, 12, 15, 0, `MIPS_FN_SUB), 1, 15, 32'hFFFF_FFFB);
    addRow(32'h0000_0000, 0, 0, 32'h0);  // nop
    addRow(iType(`MIPS_OP_ADDI, 15, 16, 16'h8000), 1, 16, 32'hFFFF_7FFB);  // -5 - 32768
    burstStart = stimTable.size();
    addRow(iType(`MIPS_OP_LW, 0, 17, 16'd20), 1, 17, 32'hFFFF_FFFD);
    // Each load takes its base from the one before, so every one stalls and the queue fills
    for (int r = 18; r < 27; r++)
      addRow(iType(`MIPS_OP_LW, regAddr_t'(r - 1), regAddr_t'(r), 16'd23), 1, regAddr_t'(r),
             32'hFFFF_FFFD);  // -3 + 23 is address 20 again
    foreach (stimTable[i])
      if (stimTable[i].expWb)
        expRows.push_back(i);
  endtask

  task automatic checkDest(input regAddr_t got, input regAddr_t exp, input int row);
    if (got !== exp) begin
      destErrors++;
      $display("[ERROR] %0t: row %0d wrote register %0d, expected %0d", $time, row, got, exp);
    end
  endtask

  task automatic checkData(input word_t got, input word_t exp, input int row);
    if (got !== exp) begin
      dataErrors++;
      $display("[ERROR] %0t: row %0d wrote %h, expected %h", $time, row, got, exp);
    end
  endtask

  task automatic checkCount(input int got, input int exp, input string what);
    if (got != exp) begin
      countErrors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic collectCredit();
    if (instrCredit) begin
      credits++;
      if (credits > `MIPS_QUEUE_DEPTH)
        checkCount(credits, `MIPS_QUEUE_DEPTH, "credit counter upper bound");
    end
  endtask

  // Match each write-back against the next expected row
  task automatic watchWriteBack();
    if (wbValid) begin
      if (wbSeen < expRows.size()) begin
        checkDest(wbResult.dest, stimTable[expRows[wbSeen]].dest, expRows[wbSeen]);
        checkData(wbResult.data, stimTable[expRows[wbSeen]].data, expRows[wbSeen]);
      end else begin
        checkCount(wbSeen + 1, expRows.size(), "write-back count");
      end
      wbSeen++;
    end
  endtask

  // Falling edge: outputs are settled, inputs change here
  task automatic nextCycle();
    @(negedge Clk);
    instrValid = 1'b0;
    collectCredit();
    watchWriteBack();
  endtask

  initial begin : stimulus
    int waitCycles;
    int gap;
    rstN          = 1'b0;
    instrValid    = 1'b0;
    instr         = '0;
    credits       = `MIPS_QUEUE_DEPTH;
    wbSeen        = 0;
    destErrors    = 0;
    dataErrors    = 0;
    countErrors   = 0;
    timedOut      = 1'b0;
    creditsRanOut = 1'b0;
    lfsr          = 16'd62001;
    buildTable();
    repeat (8) @(negedge Clk);
    rstN = 1'b1;
    nextCycle();
    checkCount(int'(instrCredit), 0, "instrCredit after reset");
    checkCount(int'(wbValid), 0, "wbValid after reset");

    for (int i = 0; i < stimTable.size(); i++) begin
      nextCycle();
      gap = (i < burstStart) ? drawGap() : 0;
      repeat (gap) nextCycle();  // Idle gap
      waitCycles = 0;
      if (credits == 0)
        creditsRanOut = 1'b1;
      while (credits == 0 && !timedOut) begin
        if (waitCycles == waitLimit) begin
          $display("Timeout: no instruction credit came back within %0d cycles", waitLimit);
          timedOut = 1'b1;
        end else begin
          nextCycle();
          waitCycles++;
        end
      end
      if (timedOut)
        break;
      instrValid = 1'b1;
      instr      = stimTable[i].instr;
      credits--;  // Spent on this push
    end

    if (!timedOut) begin
      nextCycle();
      waitCycles = 0;
      while ((wbSeen < expRows.size() || credits != `MIPS_QUEUE_DEPTH) && !timedOut) begin
        if (waitCycles == waitLimit) begin
          $display("Timeout: pipeline did not drain within %0d cycles", waitLimit);
          timedOut = 1'b1;
        end else begin
          nextCycle();
          waitCycles++;
        end
      end
    end
    if (!timedOut) begin
      repeat (6) nextCycle();  // Catch stray write-backs
      checkCount(wbSeen, expRows.size(), "write-back count");
      checkCount(credits, `MIPS_QUEUE_DEPTH, "credits held at end");
      checkCount(int'(creditsRanOut), 1, "credit exhaustion in the load burst");
    end

    $display("Errors: dest %0d, data %0d, count %0d, timeout %0d",
             destErrors, dataErrors, countErrors, timedOut);
    if (destErrors + dataErrors + countErrors == 0 && !timedOut)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/pipelineTop.sv
testbench/pipelineTb.sv
